/* hdl/modexp_pkg.sv */
`default_nettype none

package modexp_pkg;

   localparam int def_op_w = 64;

   // first multiplier operand
   typedef enum logic {
      a_acc     = 1'b0,
      a_base_in = 1'b1
   } a_sel_e;

   // second multiplier operand
   typedef enum logic [1:0] {
      b_acc   = 2'd0,
      b_mbase = 2'd1,
      b_r2    = 2'd2,
      b_one   = 2'd3
   } b_sel_e;

   // controller to datapath
   typedef struct packed {
      logic   mul_start;    // one cycle pulse
      a_sel_e a_sel;
      b_sel_e b_sel;
      logic   acc_init;     // acc <= r_mod
      logic   acc_take;     // acc <= product
      logic   mbase_take;   // mbase <= product
   } dp_cmd_t;

endpackage

`default_nettype wire

/* hdl/mont_mul.sv */
`timescale 1ns/1ps
`default_nettype none

module mont_mul #(
   parameter int op_w = 64
) (
   input  logic            clk,
   input  logic            rst,
   input  logic            start,
   input  logic [op_w-1:0] a,
   input  logic [op_w-1:0] b,
   input  logic [op_w-1:0] m,
   output logic [op_w-1:0] product,
   output logic            done
);

   localparam int cnt_w = $clog2(op_w + 1);

   logic [op_w-1:0]  a_sh;   // remaining multiplier bits from the lsb
   logic [op_w-1:0]  b_r;
   logic [op_w-1:0]  m_r;
   logic [op_w:0]    acc;    // stays below 2m
   logic [op_w:0]    acc_sub;
   logic [cnt_w-1:0] cnt;
   logic             run;
   logic             red;    // final subtract cycle

   // one radix-2 step computes (acc + a_bit*b + q*m) / 2
   function automatic logic [op_w:0] mont_step(
      input logic [op_w:0]   acc_in,
      input logic            a_bit,
      input logic [op_w-1:0] bv,
      input logic [op_w-1:0] mv
   );
      logic [op_w+1:0] sum;
      sum = {1'b0, acc_in} + (a_bit ? {2'b00, bv} : {(op_w + 2){1'b0}});
      if (sum[0]) begin
         sum = sum + {2'b00, mv};
      end
      return sum[op_w+1:1];
   endfunction

   assign acc_sub = acc - {1'b0, m_r};   // msb set means acc < m

   always_ff @(posedge clk) begin
      if (rst) begin
         run  <= 1'b0;
         red  <= 1'b0;
         done <= 1'b0;
      end else begin
         done <= red && !start;
         if (start) begin
            run <= 1'b1;
            red <= 1'b0;
         end else if (run && cnt == cnt_w'(1)) begin
            run <= 1'b0;
            red <= 1'b1;
         end else begin
            red <= 1'b0;
         end
      end
   end

   // first step runs on the start edge from the live inputs
   always_ff @(posedge clk) begin
      if (start) begin
         a_sh <= a >> 1;
         b_r  <= b;
         m_r  <= m;
         acc  <= mont_step({(op_w + 1){1'b0}}, a[0], b, m);
         cnt  <= cnt_w'(op_w - 1);
      end else if (run) begin
         a_sh <= a_sh >> 1;
         acc  <= mont_step(acc, a_sh[0], b_r, m_r);
         cnt  <= cnt - 1'b1;
      end
      if (red) begin
         product <= acc_sub[op_w] ? acc[op_w-1:0] : acc_sub[op_w-1:0];
      end
   end

endmodule

`default_nettype wire

/* hdl/exp_scanner.sv */
`timescale 1ns/1ps
`default_nettype none

module exp_scanner #(
   parameter int op_w = 64
) (
   input  logic            clk,
   input  logic            rst,
   input  logic            load,
   input  logic            shift,
   input  logic [op_w-1:0] exponent,
   output logic            exp_bit,
   output logic            exp_last
);

   localparam int cnt_w = $clog2(op_w + 1);

   logic [op_w-1:0]  exp_sh;
   logic [cnt_w-1:0] cnt;   // bits still to process

   always_ff @(posedge clk) begin
      if (rst) begin
         cnt <= '0;
      end else if (load) begin
         cnt <= cnt_w'(op_w);
      end else if (shift && cnt != '0) begin
         cnt <= cnt - 1'b1;
      end
   end

   // msb first
   always_ff @(posedge clk) begin
      if (load) begin
         exp_sh <= exponent;
      end else if (shift) begin
         exp_sh <= exp_sh << 1;
      end
   end

   assign exp_bit  = exp_sh[op_w-1];
   assign exp_last = (cnt == cnt_w'(1));

endmodule

`default_nettype wire

/* hdl/modexp_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module modexp_datapath #(
   parameter int op_w = 64
) (
   input  logic                clk,
   input  logic                rst,
   input  modexp_pkg::dp_cmd_t cmd,
   input  logic [op_w-1:0]     base,
   input  logic [op_w-1:0]     modulus,
   input  logic [op_w-1:0]     r_mod,
   input  logic [op_w-1:0]     r2_mod,
   output logic [op_w-1:0]     product,
   output logic                mul_done
);

   logic [op_w-1:0] acc;     // running power in montgomery form
   logic [op_w-1:0] mbase;   // base * R mod m
   logic [op_w-1:0] mul_a;
   logic [op_w-1:0] mul_b;

   always_ff @(posedge clk) begin
      if (cmd.acc_init) begin
         acc <= r_mod;   // montgomery one
      end else if (cmd.acc_take) begin
         acc <= product;
      end
      if (cmd.mbase_take) begin
         mbase <= product;
      end
   end

   assign mul_a = (cmd.a_sel == modexp_pkg::a_base_in) ? base : acc;

   always_comb begin
      case (cmd.b_sel)
         modexp_pkg::b_acc:   mul_b = acc;
         modexp_pkg::b_mbase: mul_b = mbase;
         modexp_pkg::b_r2:    mul_b = r2_mod;
         default:             mul_b = op_w'(1);   // back to normal form
      endcase
   end

   mont_mul #(
      .op_w (op_w)
   ) u_mont_mul (
      .clk     (clk),
      .rst     (rst),
      .start   (cmd.mul_start),
      .a       (mul_a),
      .b       (mul_b),
      .m       (modulus),
      .product (product),
      .done    (mul_done)
   );

endmodule

`default_nettype wire

/* hdl/modexp_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module modexp_ctrl (
   input  logic                clk,
   input  logic                rst,
   input  logic                start,
   input  logic                mul_done,
   input  logic                exp_bit,
   input  logic                exp_last,
   output modexp_pkg::dp_cmd_t cmd,
   output logic                exp_load,
   output logic                exp_shift,
   output logic                busy,
   output logic                finish
);

   typedef enum logic [2:0] {
      st_idle,
      st_map,     // base * r2 -> mbase
      st_sqr,
      st_mul,
      st_shift,
      st_conv     // acc * 1 -> result
   } state_e;

   state_e state;
   state_e state_n;
   logic   pend;   // multiply due this cycle

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= st_idle;
         pend  <= 1'b0;
      end else begin
         state <= state_n;
         pend  <= (state_n != state) && (state_n != st_idle) && (state_n != st_shift);
      end
   end

   always_comb begin
      state_n       = state;
      cmd           = '0;
      cmd.mul_start = pend;
      cmd.a_sel     = modexp_pkg::a_acc;
      cmd.b_sel     = modexp_pkg::b_acc;
      exp_load      = 1'b0;
      exp_shift     = 1'b0;
      finish        = 1'b0;
      case (state)
         st_idle: begin
            if (start) begin
               exp_load     = 1'b1;
               cmd.acc_init = 1'b1;
               state_n      = st_map;
            end
         end
         st_map: begin
            cmd.a_sel = modexp_pkg::a_base_in;
            cmd.b_sel = modexp_pkg::b_r2;
            if (mul_done) begin
               cmd.mbase_take = 1'b1;
               state_n        = st_sqr;
            end
         end
         st_sqr: begin
            if (mul_done) begin
               cmd.acc_take = 1'b1;
               state_n      = exp_bit ? st_mul : st_shift;
            end
         end
         st_mul: begin
            cmd.b_sel = modexp_pkg::b_mbase;
            if (mul_done) begin
               cmd.acc_take = 1'b1;
               state_n      = st_shift;
            end
         end
         st_shift: begin
            exp_shift = 1'b1;
            state_n   = exp_last ? st_conv : st_sqr;   // last bit done
         end
         st_conv: begin
            cmd.b_sel = modexp_pkg::b_one;
            if (mul_done) begin
               finish  = 1'b1;
               state_n = st_idle;
            end
         end
         default: state_n = st_idle;
      endcase
   end

   assign busy = (state != st_idle);

endmodule

`default_nettype wire

/* hdl/modexp_top.sv */
`timescale 1ns/1ps
`default_nettype none

module modexp_top #(
   parameter int op_w = modexp_pkg::def_op_w
) (
   input  logic            clk,
   input  logic            rst,
   input  logic            start,
   input  logic [op_w-1:0] base,
   input  logic [op_w-1:0] exponent,
   input  logic [op_w-1:0] modulus,
   input  logic [op_w-1:0] r_mod,
   input  logic [op_w-1:0] r2_mod,
   output logic            busy,
   output logic            done,
   output logic [op_w-1:0] result
);

   modexp_pkg::dp_cmd_t cmd;
   logic [op_w-1:0]     product;
   logic                mul_done;
   logic                exp_load;
   logic                exp_shift;
   logic                exp_bit;
   logic                exp_last;
   logic                finish;

   modexp_ctrl u_ctrl (
      .clk       (clk),
      .rst       (rst),
      .start     (start),
      .mul_done  (mul_done),
      .exp_bit   (exp_bit),
      .exp_last  (exp_last),
      .cmd       (cmd),
      .exp_load  (exp_load),
      .exp_shift (exp_shift),
      .busy      (busy),
      .finish    (finish)
   );

   exp_scanner #(
      .op_w (op_w)
   ) u_scanner (
      .clk      (clk),
      .rst      (rst),
      .load     (exp_load),
      .shift    (exp_shift),
      .exponent (exponent),
      .exp_bit  (exp_bit),
      .exp_last (exp_last)
   );

   modexp_datapath #(
      .op_w (op_w)
   ) u_datapath (
      .clk      (clk),
      .rst      (rst),
      .cmd      (cmd),
      .base     (base),
      .modulus  (modulus),
      .r_mod    (r_mod),
      .r2_mod   (r2_mod),
      .product  (product),
      .mul_done (mul_done)
   );

   // result held until the next completion
   always_ff @(posedge clk) begin
      if (rst) begin
         done   <= 1'b0;
         result <= '0;
      end else begin
         done <= finish;
         if (finish) begin
            result <= product;
         end
      end
   end

endmodule

`default_nettype wire

/* dv/modexp_ref.svh */
// product of two residues at double width
function automatic logic [op_w-1:0] mul_mod(input logic [op_w-1:0] a,
                                            input logic [op_w-1:0] b,
                                            input logic [op_w-1:0] m);
   logic [2*op_w-1:0] p;
   p = {{op_w{1'b0}}, a} * {{op_w{1'b0}}, b};
   return op_w'(p % {{op_w{1'b0}}, m});
endfunction

// plain square and multiply from the msb
function automatic logic [op_w-1:0] pow_mod(input logic [op_w-1:0] b,
                                            input logic [op_w-1:0] e,
                                            input logic [op_w-1:0] m);
   logic [op_w-1:0] acc;
   int              i;
   acc = op_w'(1);   // m > 1
   for (i = op_w - 1; i >= 0; i--) begin
      acc = mul_mod(acc, acc, m);
      if (e[i]) begin
         acc = mul_mod(acc, b, m);
      end
   end
   return acc;
endfunction

// 2^op_w mod m
function automatic logic [op_w-1:0] mont_r(input logic [op_w-1:0] m);
   logic [2*op_w-1:0] r;
   r       = '0;
   r[op_w] = 1'b1;
   return op_w'(r % {{op_w{1'b0}}, m});
endfunction

function automatic logic [op_w-1:0] mont_r2(input logic [op_w-1:0] m);
   logic [op_w-1:0] r;
   r = mont_r(m);
   return mul_mod(r, r, m);
endfunction

// fibonacci lfsr with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
   return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

/* dv/modexp_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module modexp_tb;

   localparam int op_w       = modexp_pkg::def_op_w;
   localparam int max_cycles = 300 * op_w;   // all-ones exponent needs about 140 * op_w
   localparam int n_random   = 20;

   logic            clk;
   logic            rst;
   logic            start;
   logic [op_w-1:0] base;
   logic [op_w-1:0] exponent;
   logic [op_w-1:0] modulus;
   logic [op_w-1:0] r_mod;
   logic [op_w-1:0] r2_mod;
   logic            busy;
   logic            done;
   logic [op_w-1:0] result;

   logic [31:0]     lfsr;
   int              errors;       // value checks and timeouts
   int              mon_errors;
   int              sva_errors;
   int              tests_run;
   int              tests_bad;
   bit              timed_out;
   logic [op_w-1:0] result_q;
   logic            busy_q;
   logic            mon_valid;

   `include "modexp_ref.svh"

   modexp_top #(
      .op_w (op_w)
   ) u_dut (
      .clk      (clk),
      .rst      (rst),
      .start    (start),
      .base     (base),
      .exponent (exponent),
      .modulus  (modulus),
      .r_mod    (r_mod),
      .r2_mod   (r2_mod),
      .busy     (busy),
      .done     (done),
      .result   (result)
   );

   always #20 clk = ~clk;

   // done is a single cycle pulse
   assert property (@(posedge clk) disable iff (rst) done |=> !done)
      else begin
         $display("CHECK FAILED done high on two cycles, done=%h", done);
         sva_errors++;
      end

   always @(posedge clk) begin
      if (rst) begin
         mon_valid <= 1'b0;
      end else begin
         if (done) begin
            assert (!busy) else begin
               $display("CHECK FAILED busy=%h while done=%h", busy, done);
               mon_errors++;
            end
         end
         if (mon_valid && !done) begin   // result holds between completions
            assert (result === result_q) else begin
               $display("CHECK FAILED result=%h changed from %h without done", result, result_q);
               mon_errors++;
            end
         end
         if (mon_valid && done) begin
            assert (busy_q) else begin
               $display("CHECK FAILED done=%h with busy=%h the cycle before", done, busy_q);
               mon_errors++;
            end
         end
         result_q  <= result;
         busy_q    <= busy;
         mon_valid <= 1'b1;
      end
   end

   function automatic int error_total();
      return errors + mon_errors + sva_errors;
   endfunction

   function automatic logic [op_w-1:0] rand_word();
      logic [op_w-1:0] w;
      int              i;
      w = '0;
      for (i = 0; i < op_w; i++) begin
         lfsr = lfsr_next(lfsr);
         w    = {w[op_w-2:0], lfsr[0]};
      end
      return w;
   endfunction

   function automatic logic [op_w-1:0] rand_modulus();
      logic [op_w-1:0] m;
      m = rand_word() | op_w'(1);
      if (m == op_w'(1)) begin
         m = op_w'(3);
      end
      return m;
   endfunction

   task automatic check_value(input string name, input logic [op_w-1:0] got,
                              input logic [op_w-1:0] exp);
      assert (got === exp) else begin
         $display("CHECK FAILED %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic end_test(input string name, input int errs_before);
      tests_run++;
      if (error_total() == errs_before) begin
         $display("test %0d %s: ok", tests_run, name);
      end else begin
         tests_bad++;
         $display("test %0d %s: FAIL", tests_run, name);
      end
   endtask

   // poke > 0 pulses start again that many cycles into the run
   task automatic run_modexp(input logic [op_w-1:0] b, input logic [op_w-1:0] e,
                             input logic [op_w-1:0] m, input int poke,
                             output logic [op_w-1:0] res);
      int cnt;
      res = '0;
      if (timed_out) begin
         return;
      end
      @(posedge clk);
      start    <= 1'b1;
      base     <= b;
      exponent <= e;
      modulus  <= m;
      r_mod    <= mont_r(m);
      r2_mod   <= mont_r2(m);
      @(posedge clk);
      start <= 1'b0;
      @(posedge clk);
      check_value("busy", op_w'(busy), op_w'(1));   // up the cycle after start
      cnt = 0;
      while (!done && cnt < max_cycles) begin
         @(posedge clk);
         start <= (poke != 0) && (cnt == poke);
         cnt++;
      end
      if (!done) begin
         $display("timeout: no done within %0d cycles", max_cycles);
         errors++;
         timed_out = 1'b1;
      end
      res = result;
   endtask

   task automatic watch_idle(input int cycles, input logic [op_w-1:0] held);
      int i;
      for (i = 0; i < cycles; i++) begin
         @(posedge clk);
         check_value("busy", op_w'(busy), '0);
         check_value("done", op_w'(done), '0);
         check_value("result", result, held);
      end
   endtask

   initial begin
      logic [op_w-1:0] m;
      logic [op_w-1:0] b;
      logic [op_w-1:0] e;
      logic [op_w-1:0] res;
      int              errs;
      int              k;
      clk        = 1'b0;
      rst        = 1'b1;
      start      = 1'b0;
      base       = '0;
      exponent   = '0;
      modulus    = '0;
      r_mod      = '0;
      r2_mod     = '0;
      lfsr       = 32'h7d06;
      errors     = 0;
      mon_errors = 0;
      sva_errors = 0;
      tests_run  = 0;
      tests_bad  = 0;
      timed_out  = 1'b0;
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);

      errs = error_total();
      @(posedge clk);
      check_value("busy", op_w'(busy), '0);
      check_value("done", op_w'(done), '0);
      check_value("result", result, '0);
      end_test("reset state", errs);

      errs = error_total();
      for (k = 0; k < n_random; k++) begin
         m = rand_modulus();
         b = rand_word() % m;
         e = rand_word();
         run_modexp(b, e, m, 0, res);
         check_value("result", res, pow_mod(b, e, m));
      end
      end_test("random operands", errs);

      errs = error_total();
      m = rand_modulus();
      b = rand_word() % m;
      run_modexp(b, '0, m, 0, res);
      check_value("result", res, op_w'(1));   // x^0
      run_modexp(b, '1, m, 0, res);
      check_value("result", res, pow_mod(b, '1, m));
      end_test("exponent corners", errs);

      errs = error_total();
      m = rand_modulus();
      run_modexp('0, rand_word() | op_w'(1), m, 0, res);
      check_value("result", res, '0);
      e = rand_word() & ~op_w'(1);
      run_modexp(m - 1'b1, e, m, 0, res);
      check_value("result", res, op_w'(1));   // (-1)^even
      run_modexp(m - 1'b1, e | op_w'(1), m, 0, res);
      check_value("result", res, m - 1'b1);
      end_test("base corners", errs);

      errs = error_total();
      m = rand_modulus();
      b = rand_word() % m;
      e = rand_word();
      run_modexp(b, e, m, 10, res);
      check_value("result", res, pow_mod(b, e, m));
      watch_idle(3 * op_w, pow_mod(b, e, m));
      end_test("start while busy", errs);

      errs = error_total();
      m = rand_modulus();
      b = rand_word() % m;
      e = rand_word();
      run_modexp(b, e, m, 0, res);
      check_value("result", res, pow_mod(b, e, m));
      watch_idle(2 * op_w, pow_mod(b, e, m));
      b = (b + 1'b1) % m;
      run_modexp(b, e, m, 0, res);
      check_value("result", res, pow_mod(b, e, m));
      end_test("done pulse and result hold", errs);

      $display("summary: %0d tests run, %0d with errors, %0d check errors",
               tests_run, tests_bad, error_total());
      if (error_total() == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* modexp.f */
+incdir+dv
hdl/modexp_pkg.sv
hdl/mont_mul.sv
hdl/exp_scanner.sv
hdl/modexp_datapath.sv
hdl/modexp_ctrl.sv
hdl/modexp_top.sv
dv/modexp_tb.sv

/* Makefile */
.PHONY: run clean

run:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module modexp_tb -f modexp.f -o modexp_sim
	@out="$$(./obj_dir/modexp_sim)"; echo "$$out"; \
		echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir
